// ==== vlog.f ====
hdl/reduce_pkg.sv
hdl/lane_select.sv
hdl/issue_ctrl.sv
hdl/lane_combine.sv
hdl/collect_unit_top.sv
tests/collect_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
	--top-module collect_unit_tb -o collect_unit_sim || exit 1

out=$(./obj_dir/collect_unit_sim)
echo "$out"

echo "$out" | grep -q "Test completed successfully" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// ==== tests/collect_unit_tb.sv ====
`timescale 1ns/1ps

module collect_unit_tb;

	localparam int DATA_WIDTH = 32;
	localparam int NUM_LANES = 16;
	localparam int CREDITS = 4;
	localparam int LANE_W = $clog2(NUM_LANES);
	localparam int CLK_PERIOD = 100;
	localparam int NUM_TESTS = 21;
	localparam int WATCHDOG_CYCLES = NUM_TESTS * 20 + 100;

	localparam int MODE_WAIT = 0;   // wait for result and credit before next row
	localparam int MODE_STREAM = 1; // next row follows at once
	localparam int MODE_HOLD = 2;   // credits withheld

	logic                            CLK;
	logic                            i_arst_n;
	logic [NUM_LANES-1:0]            i_valid;
	logic [NUM_LANES*DATA_WIDTH-1:0] i_data_bus;
	logic                            i_req_valid;
	logic [LANE_W-1:0]               i_req_sel_a;
	logic [LANE_W-1:0]               i_req_sel_b;
	reduce_pkg::op_t                 i_req_op;
	logic                            o_req_ready;
	logic                            o_res_valid;
	logic [DATA_WIDTH:0]             o_res_data;
	reduce_pkg::contrib_t            o_res_count;
	logic                            i_credit_return = 1'b0;

	// stimulus table
	string                names[NUM_TESTS];
	logic [NUM_LANES-1:0] masks[NUM_TESTS];
	logic [LANE_W-1:0]    sels_a[NUM_TESTS];
	logic [LANE_W-1:0]    sels_b[NUM_TESTS];
	reduce_pkg::op_t      ops[NUM_TESTS];
	int                   modes[NUM_TESTS];
	int                   row_cnt = 0;

	// expected results in request order
	int                   exp_idx[$];
	int                   exp_cycle[$];
	logic [DATA_WIDTH:0]  exp_data[$];
	reduce_pkg::contrib_t exp_count[$];

	logic [DATA_WIDTH-1:0] lane_word[NUM_LANES];
	logic [31:0]           lfsr_state = 32'd62;
	int                    cycle_cnt = 0;
	int                    res_seen = 0;
	int                    credits_back = 0;
	logic                  hold_credits = 1'b0;
	int                    hold_accepts = 0;
	int                    pass_count = 0;
	int                    fail_count = 0;
	int                    res_errors = 0;
	int                    flow_errors = 0;

	collect_unit_top #(
		.DATA_WIDTH (DATA_WIDTH),
		.NUM_LANES  (NUM_LANES),
		.CREDITS    (CREDITS)
	) DUT (
		.CLK             (CLK),
		.i_arst_n        (i_arst_n),
		.i_valid         (i_valid),
		.i_data_bus      (i_data_bus),
		.i_req_valid     (i_req_valid),
		.i_req_sel_a     (i_req_sel_a),
		.i_req_sel_b     (i_req_sel_b),
		.i_req_op        (i_req_op),
		.o_req_ready     (o_req_ready),
		.o_res_valid     (o_res_valid),
		.o_res_data      (o_res_data),
		.o_res_count     (o_res_count),
		.i_credit_return (i_credit_return)
	);

	initial
	begin
		CLK = 1'b0;
		forever #(CLK_PERIOD / 2) CLK = ~CLK;
	end

	always @(posedge CLK)
	begin
		cycle_cnt <= cycle_cnt + 1;
	end

	// x^32+x^22+x^2+x+1, right shifting
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		lfsr_step = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic next_word(output logic [DATA_WIDTH-1:0] w);
		for (int i = 0; i < DATA_WIDTH; i++)
		begin
			lfsr_state = lfsr_step(lfsr_state);
			w[i] = lfsr_state[0];
		end
	endtask

	// invalid lanes still carry random data
	task automatic fill_lanes(input logic [NUM_LANES-1:0] mask);
		logic [DATA_WIDTH-1:0] w;
		for (int l = 0; l < NUM_LANES; l++)
		begin
			next_word(w);
			lane_word[l] = w;
			i_data_bus[l*DATA_WIDTH +: DATA_WIDTH] = w;
		end
		i_valid = mask;
	endtask

	function automatic logic [DATA_WIDTH:0] model_result(input reduce_pkg::op_t op,
			input logic va, input logic [DATA_WIDTH-1:0] da,
			input logic vb, input logic [DATA_WIDTH-1:0] db);
		logic [DATA_WIDTH:0] a;
		logic [DATA_WIDTH:0] b;
		a = va ? {1'b0, da} : '0;
		b = vb ? {1'b0, db} : '0;
		if (op == reduce_pkg::OP_ADD)
			model_result = a + b;
		else if (op == reduce_pkg::OP_PASS_A)
			model_result = a;
		else if (!(va && vb))
			model_result = a | b; // at most one is nonzero
		else if (op == reduce_pkg::OP_MAX)
			model_result = (a > b) ? a : b;
		else
			model_result = (a < b) ? a : b;
	endfunction

	function automatic reduce_pkg::contrib_t model_count(input reduce_pkg::op_t op,
			input logic va, input logic vb);
		if (op == reduce_pkg::OP_PASS_A)
			model_count = {1'b0, va};
		else
			model_count = {1'b0, va} + {1'b0, vb};
	endfunction

	task automatic add_row(input string n, input logic [NUM_LANES-1:0] m, input int a,
			input int b, input reduce_pkg::op_t op, input int mode);
		names[row_cnt] = n;
		masks[row_cnt] = m;
		sels_a[row_cnt] = LANE_W'(a);
		sels_b[row_cnt] = LANE_W'(b);
		ops[row_cnt] = op;
		modes[row_cnt] = mode;
		row_cnt++;
	endtask

	task automatic load_table();
		add_row("add_both_valid", 16'hFFFF, 3, 9, reduce_pkg::OP_ADD, MODE_WAIT);
		add_row("max_both_valid", 16'hFFFF, 0, 15, reduce_pkg::OP_MAX, MODE_WAIT);
		add_row("min_both_valid", 16'hFFFF, 7, 2, reduce_pkg::OP_MIN, MODE_WAIT);
		add_row("pass_both_valid", 16'hFFFF, 5, 6, reduce_pkg::OP_PASS_A, MODE_WAIT);
		add_row("add_b_invalid", 16'hFFEF, 1, 4, reduce_pkg::OP_ADD, MODE_WAIT);
		add_row("max_a_invalid", 16'hFF7F, 7, 8, reduce_pkg::OP_MAX, MODE_WAIT);
		add_row("min_b_invalid", 16'hFDFF, 10, 9, reduce_pkg::OP_MIN, MODE_WAIT);
		add_row("add_none_valid", 16'h0000, 2, 3, reduce_pkg::OP_ADD, MODE_WAIT);
		add_row("max_none_valid", 16'h0000, 12, 13, reduce_pkg::OP_MAX, MODE_WAIT);
		add_row("pass_a_invalid", 16'hFFFE, 0, 1, reduce_pkg::OP_PASS_A, MODE_WAIT);
		add_row("pass_b_invalid", 16'hFFF7, 2, 3, reduce_pkg::OP_PASS_A, MODE_WAIT);
		add_row("stream_add", 16'hA5A5, 0, 2, reduce_pkg::OP_ADD, MODE_STREAM);
		add_row("stream_max", 16'h5A5A, 1, 3, reduce_pkg::OP_MAX, MODE_STREAM);
		add_row("stream_min", 16'hF0F0, 4, 12, reduce_pkg::OP_MIN, MODE_STREAM);
		add_row("stream_pass", 16'h0F0F, 3, 8, reduce_pkg::OP_PASS_A, MODE_STREAM);
		add_row("stream_same_lane", 16'hFFFF, 11, 11, reduce_pkg::OP_ADD, MODE_WAIT);
		add_row("hold_0", 16'hFFFF, 6, 14, reduce_pkg::OP_ADD, MODE_HOLD);
		add_row("hold_1", 16'hFFFF, 9, 1, reduce_pkg::OP_MAX, MODE_HOLD);
		add_row("hold_2", 16'hFFFF, 13, 5, reduce_pkg::OP_MIN, MODE_HOLD);
		add_row("hold_3", 16'hBFFF, 14, 0, reduce_pkg::OP_ADD, MODE_HOLD);
		add_row("hold_4_blocked", 16'hFFFF, 15, 10, reduce_pkg::OP_MAX, MODE_HOLD);
	endtask

	task automatic to_drive_point();
		@(posedge CLK);
		#10;
	endtask

	// every result back and every credit handed back
	task automatic wait_drain();
		while (exp_idx.size() != 0 || credits_back != res_seen)
			@(negedge CLK);
	endtask

	task automatic check_hold();
		if (hold_accepts < CREDITS)
		begin
			if (!o_req_ready)
			begin
				flow_errors++;
				$display("o_req_ready fell after %0d acceptances, %0d credits expected",
					hold_accepts, CREDITS);
			end
		end
		else
		begin
			repeat (6)
			begin
				if (o_req_ready)
				begin
					flow_errors++;
					$display("o_req_ready is high although all credits are spent");
				end
				@(negedge CLK);
			end
			if (exp_idx.size() != 0)
			begin
				flow_errors++;
				$display("results of accepted requests are missing while credits are held");
			end
			hold_credits = 1'b0;
		end
	endtask

	task automatic wait_accept(input int t, input logic [DATA_WIDTH:0] e_data,
			input reduce_pkg::contrib_t e_count);
		int acc;
		@(negedge CLK);
		if (modes[t] == MODE_HOLD)
			check_hold();
		while (!o_req_ready)
			@(negedge CLK);
		acc = cycle_cnt; // cycle in which the request is taken
		to_drive_point();
		exp_idx.push_back(t);
		exp_cycle.push_back(acc);
		exp_data.push_back(e_data);
		exp_count.push_back(e_count);
		if (modes[t] == MODE_HOLD)
			hold_accepts++;
	endtask

	task automatic check_result();
		int t;
		int acc;
		logic [DATA_WIDTH:0] e_data;
		reduce_pkg::contrib_t e_count;
		logic ok;
		t = exp_idx.pop_front();
		acc = exp_cycle.pop_front();
		e_data = exp_data.pop_front();
		e_count = exp_count.pop_front();
		ok = 1'b1;
		if (o_res_data !== e_data)
		begin
			$display("CHECK FAILED %s data: expected %h, actual %h", names[t], e_data, o_res_data);
			ok = 1'b0;
		end
		if (o_res_count !== e_count)
		begin
			$display("CHECK FAILED %s count: expected %0d, actual %0d", names[t], e_count,
				o_res_count);
			ok = 1'b0;
		end
		if (cycle_cnt != acc + 2)
		begin
			$display("CHECK FAILED %s latency: expected 2, actual %0d", names[t], cycle_cnt - acc);
			ok = 1'b0;
		end
		if (ok)
			pass_count++;
		else
			fail_count++;
		$display("test %0d %s: %s", t, names[t], ok ? "ok" : "mismatch");
	endtask

	always @(negedge CLK)
	begin
		if (i_arst_n && o_res_valid)
		begin
			res_seen++;
			if (exp_idx.size() == 0)
			begin
				res_errors++;
				$display("result %h appeared with no request outstanding", o_res_data);
			end
			else
			begin
				check_result();
			end
		end
	end

	// consumer frees one slot per result unless held
	always @(posedge CLK)
	begin
		#10;
		if (!hold_credits && res_seen > credits_back)
		begin
			i_credit_return = 1'b1;
			credits_back++;
		end
		else
		begin
			i_credit_return = 1'b0;
		end
	end

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired after %0d cycles before the run finished", WATCHDOG_CYCLES);
		$display("Test failed");
		$finish;
	end

	initial
	begin
		logic [DATA_WIDTH:0]  e_data;
		reduce_pkg::contrib_t e_count;
		i_arst_n = 1'b0;
		i_valid = '0;
		i_data_bus = '0;
		i_req_valid = 1'b0;
		i_req_sel_a = '0;
		i_req_sel_b = '0;
		i_req_op = reduce_pkg::OP_ADD;
		load_table();
		repeat (5) @(posedge CLK);
		#10;
		i_arst_n = 1'b1;

		if (o_res_valid !== 1'b0 || o_req_ready !== 1'b1)
		begin
			flow_errors++;
			$display("CHECK FAILED reset_state: expected valid 0 ready 1, actual valid %b ready %b",
				o_res_valid, o_req_ready);
		end
		$display("reset_state: done");
		to_drive_point();

		for (int t = 0; t < NUM_TESTS; t++)
		begin
			if (modes[t] == MODE_HOLD && hold_accepts == 0)
			begin
				wait_drain();
				hold_credits = 1'b1;
				to_drive_point();
			end
			fill_lanes(masks[t]);
			e_data = model_result(ops[t], masks[t][sels_a[t]], lane_word[sels_a[t]],
				masks[t][sels_b[t]], lane_word[sels_b[t]]);
			e_count = model_count(ops[t], masks[t][sels_a[t]], masks[t][sels_b[t]]);
			i_req_sel_a = sels_a[t];
			i_req_sel_b = sels_b[t];
			i_req_op = ops[t];
			i_req_valid = 1'b1;
			wait_accept(t, e_data, e_count);
			i_req_valid = 1'b0;
			if (modes[t] == MODE_WAIT)
			begin
				wait_drain();
				to_drive_point();
			end
		end
		wait_drain();
		repeat (3) @(negedge CLK);

		$display("tests %0d, passed %0d, mismatched %0d, result errors %0d, flow errors %0d",
			NUM_TESTS, pass_count, fail_count, res_errors, flow_errors);
		if (pass_count == NUM_TESTS && fail_count == 0 && res_errors == 0 && flow_errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// ==== hdl/collect_unit_top.sv ====
`timescale 1ns/1ps

module collect_unit_top #(
	parameter int DATA_WIDTH = 32,
	parameter int NUM_LANES = 16,  // power of two
	parameter int CREDITS = 4      // downstream buffer depth
)(
	input  logic                            CLK,
	input  logic                            i_arst_n,

	// multiplier lanes
	input  logic [NUM_LANES-1:0]            i_valid,
	input  logic [NUM_LANES*DATA_WIDTH-1:0] i_data_bus,

	// request side, held until accepted
	input  logic                            i_req_valid,
	input  logic [$clog2(NUM_LANES)-1:0]    i_req_sel_a,
	input  logic [$clog2(NUM_LANES)-1:0]    i_req_sel_b,
	input  reduce_pkg::op_t                 i_req_op,
	output logic                            o_req_ready,

	// result side, credit flow control
	output logic                            o_res_valid,
	output logic [DATA_WIDTH:0]             o_res_data,
	output reduce_pkg::contrib_t            o_res_count,
	input  logic                            i_credit_return
);

	logic                  issue;
	logic [NUM_LANES-1:0]  cmd_a;
	logic [NUM_LANES-1:0]  cmd_b;
	reduce_pkg::op_t       op;

	logic                  sel_valid_a;
	logic [DATA_WIDTH-1:0] sel_data_a;
	logic                  sel_valid_b;
	logic [DATA_WIDTH-1:0] sel_data_b;

	issue_ctrl #(
		.NUM_LANES (NUM_LANES),
		.CREDITS   (CREDITS)
	) u_issue (
		.CLK             (CLK),
		.i_arst_n        (i_arst_n),
		.i_req_valid     (i_req_valid),
		.i_req_sel_a     (i_req_sel_a),
		.i_req_sel_b     (i_req_sel_b),
		.i_req_op        (i_req_op),
		.o_req_ready     (o_req_ready),
		.i_credit_return (i_credit_return),
		.o_issue         (issue),
		.o_cmd_a         (cmd_a),
		.o_cmd_b         (cmd_b),
		.o_op            (op)
	);

	// operand a
	lane_select #(
		.DATA_WIDTH (DATA_WIDTH),
		.NUM_LANES  (NUM_LANES)
	) u_sel_a (
		.CLK        (CLK),
		.i_arst_n   (i_arst_n),
		.i_en       (issue),
		.i_cmd      (cmd_a),
		.i_valid    (i_valid),
		.i_data_bus (i_data_bus),
		.o_valid    (sel_valid_a),
		.o_data     (sel_data_a)
	);

	// operand b
	lane_select #(
		.DATA_WIDTH (DATA_WIDTH),
		.NUM_LANES  (NUM_LANES)
	) u_sel_b (
		.CLK        (CLK),
		.i_arst_n   (i_arst_n),
		.i_en       (issue),
		.i_cmd      (cmd_b),
		.i_valid    (i_valid),
		.i_data_bus (i_data_bus),
		.o_valid    (sel_valid_b),
		.o_data     (sel_data_b)
	);

	lane_combine #(
		.DATA_WIDTH (DATA_WIDTH)
	) u_combine (
		.CLK         (CLK),
		.i_arst_n    (i_arst_n),
		.i_issue     (issue),
		.i_op        (op),
		.i_valid_a   (sel_valid_a),
		.i_data_a    (sel_data_a),
		.i_valid_b   (sel_valid_b),
		.i_data_b    (sel_data_b),
		.o_res_valid (o_res_valid),
		.o_res_data  (o_res_data),
		.o_res_count (o_res_count)
	);

endmodule

// ==== hdl/lane_combine.sv ====
`timescale 1ns/1ps

module lane_combine #(
	parameter int DATA_WIDTH = 32
)(
	input  logic                 CLK,
	input  logic                 i_arst_n,

	input  logic                 i_issue,
	input  reduce_pkg::op_t      i_op,

	input  logic                 i_valid_a,
	input  logic [DATA_WIDTH-1:0] i_data_a,
	input  logic                 i_valid_b,
	input  logic [DATA_WIDTH-1:0] i_data_b,

	output logic                 o_res_valid,
	output logic [DATA_WIDTH:0]  o_res_data,   // one extra bit for the sum carry
	output reduce_pkg::contrib_t o_res_count
);

	logic                  issue_q;
	reduce_pkg::op_t       op_q;
	logic [DATA_WIDTH-1:0] max_val;
	logic [DATA_WIDTH-1:0] min_val;
	reduce_pkg::contrib_t  both_count;
	logic [DATA_WIDTH:0]   res_next;
	reduce_pkg::contrib_t  count_next;

	// same stage as the selector registers
	always_ff @(posedge CLK or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			issue_q <= 1'b0;
		end
		else
		begin
			issue_q <= i_issue;
		end
	end

	always_ff @(posedge CLK)
	begin
		op_q <= i_op;
	end

	// only valid operands take part in max/min
	always_comb
	begin
		max_val = '0;
		min_val = '0;
		if (i_valid_a && i_valid_b)
		begin
			max_val = (i_data_a > i_data_b) ? i_data_a : i_data_b;
			min_val = (i_data_a < i_data_b) ? i_data_a : i_data_b;
		end
		else if (i_valid_a)
		begin
			max_val = i_data_a;
			min_val = i_data_a;
		end
		else if (i_valid_b)
		begin
			max_val = i_data_b;
			min_val = i_data_b;
		end
	end

	always_comb
	begin
		case ({i_valid_a, i_valid_b})
			2'b11:        both_count = reduce_pkg::CONTRIB_TWO;
			2'b10, 2'b01: both_count = reduce_pkg::CONTRIB_ONE;
			default:      both_count = reduce_pkg::CONTRIB_NONE;
		endcase
	end

	always_comb
	begin
		count_next = both_count;
		case (op_q)
			reduce_pkg::OP_ADD:    res_next = {1'b0, i_data_a} + {1'b0, i_data_b};
			reduce_pkg::OP_MAX:    res_next = {1'b0, max_val};
			reduce_pkg::OP_MIN:    res_next = {1'b0, min_val};
			reduce_pkg::OP_PASS_A:
			begin
				res_next = {1'b0, i_data_a};
				count_next = i_valid_a ? reduce_pkg::CONTRIB_ONE : reduce_pkg::CONTRIB_NONE;
			end
			default:               res_next = '0;
		endcase
	end

	always_ff @(posedge CLK or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			o_res_valid <= 1'b0;
		end
		else
		begin
			o_res_valid <= issue_q;
		end
	end

	always_ff @(posedge CLK)
	begin
		if (issue_q)
		begin
			o_res_data <= res_next;
			o_res_count <= count_next;
		end
	end

	// selector outputs must sit in the stage right after an issue
	a_operand_align: assert property (
		@(posedge CLK) disable iff (!i_arst_n)
		(i_valid_a || i_valid_b) |-> issue_q
	) else $error("lane_combine: operand valid outside the issued stage");

endmodule

// ==== hdl/issue_ctrl.sv ====
`timescale 1ns/1ps

module issue_ctrl #(
	parameter int NUM_LANES = 16,
	parameter int CREDITS = 4
)(
	input  logic                         CLK,
	input  logic                         i_arst_n,

	input  logic                         i_req_valid,
	input  logic [$clog2(NUM_LANES)-1:0] i_req_sel_a,
	input  logic [$clog2(NUM_LANES)-1:0] i_req_sel_b,
	input  reduce_pkg::op_t              i_req_op,
	output logic                         o_req_ready,

	input  logic                         i_credit_return,

	output logic                         o_issue,   // enable for selectors and combiner
	output logic [NUM_LANES-1:0]         o_cmd_a,
	output logic [NUM_LANES-1:0]         o_cmd_b,
	output reduce_pkg::op_t              o_op
);

	localparam int CNT_W = $clog2(CREDITS + 1);

	typedef logic [CNT_W-1:0] credit_t;

	localparam credit_t CNT_FULL = credit_t'(CREDITS);

	credit_t credit_cnt;
	logic    accept;

	// one free slot downstream is enough to take a request
	assign o_req_ready = (credit_cnt != '0);
	assign accept = i_req_valid && o_req_ready;
	assign o_issue = accept;
	assign o_op = i_req_op;

	// index to one-hot, quiet unless a request is taken
	always_comb
	begin
		o_cmd_a = '0;
		o_cmd_b = '0;
		if (accept)
		begin
			o_cmd_a[i_req_sel_a] = 1'b1;
			o_cmd_b[i_req_sel_b] = 1'b1;
		end
	end

	// spend on accept, regain on return
	always_ff @(posedge CLK or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			credit_cnt <= CNT_FULL;
		end
		else
		begin
			case ({accept, i_credit_return})
				2'b10:   credit_cnt <= credit_cnt - 1'b1;
				2'b01:   credit_cnt <= credit_cnt + 1'b1;
				default: credit_cnt <= credit_cnt; // both or neither
			endcase
		end
	end

	a_credit_bound: assert property (
		@(posedge CLK) disable iff (!i_arst_n)
		credit_cnt <= CNT_FULL
	) else $error("issue_ctrl: credit count above %0d", CREDITS);

	// consumer must not hand back more than it was given
	a_no_excess_return: assert property (
		@(posedge CLK) disable iff (!i_arst_n)
		i_credit_return |-> (credit_cnt < CNT_FULL)
	) else $error("issue_ctrl: credit returned while credits full");

endmodule

// ==== hdl/lane_select.sv ====
`timescale 1ns/1ps

module lane_select #(
	parameter int DATA_WIDTH = 32,
	parameter int NUM_LANES = 16
)(
	input  logic                            CLK,
	input  logic                            i_arst_n,

	input  logic                            i_en,
	input  logic [NUM_LANES-1:0]            i_cmd,     // one-hot lane pick

	input  logic [NUM_LANES-1:0]            i_valid,
	input  logic [NUM_LANES*DATA_WIDTH-1:0] i_data_bus,

	output logic                            o_valid,
	output logic [DATA_WIDTH-1:0]           o_data
);

	logic                  cmd_onehot;
	logic                  hit_valid;
	logic [DATA_WIDTH-1:0] hit_data;
	logic                  next_valid;
	logic [DATA_WIDTH-1:0] next_data;

	// exactly one bit set
	assign cmd_onehot = (i_cmd != '0) && ((i_cmd & (i_cmd - 1'b1)) == '0);

	// and-or mux over all lanes
	always_comb
	begin
		hit_valid = 1'b0;
		hit_data = '0;
		for (int i = 0; i < NUM_LANES; i++)
		begin
			if (i_cmd[i])
			begin
				hit_valid = hit_valid | i_valid[i];
				hit_data = hit_data | i_data_bus[i*DATA_WIDTH +: DATA_WIDTH];
			end
		end
	end

	// invalid lane, bad cmd or idle all read as zero
	assign next_valid = i_en && cmd_onehot && hit_valid;
	assign next_data = next_valid ? hit_data : '0;

	always_ff @(posedge CLK or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			o_valid <= 1'b0;
		end
		else
		begin
			o_valid <= next_valid;
		end
	end

	always_ff @(posedge CLK)
	begin
		o_data <= next_data;
	end

	// commands come from issue_ctrl, decoded from an index
	a_cmd_onehot: assert property (
		@(posedge CLK) disable iff (!i_arst_n)
		i_en |-> $onehot(i_cmd)
	) else $error("lane_select: command not one-hot while enabled");

endmodule

// ==== hdl/reduce_pkg.sv ====
package reduce_pkg;

	localparam int OP_W = 2;
	localparam int CONTRIB_W = 2;

	// reduction applied to the two selected operands
	typedef logic [OP_W-1:0] op_t;

	// operands that fed a result, 0 to 2
	typedef logic [CONTRIB_W-1:0] contrib_t;

	localparam op_t OP_ADD    = 2'd0; // unsigned sum
	localparam op_t OP_MAX    = 2'd1; // larger valid operand
	localparam op_t OP_MIN    = 2'd2; // smaller valid operand
	localparam op_t OP_PASS_A = 2'd3; // operand a as is

	localparam contrib_t CONTRIB_NONE = 2'd0;
	localparam contrib_t CONTRIB_ONE  = 2'd1;
	localparam contrib_t CONTRIB_TWO  = 2'd2;

endpackage
